/* bench/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// digest fold over at most KV_PASS_MAX chars
function automatic logic [31:0] ref_digest(input logic [7:0] chars[$]);
	logic [31:0] d;
	d = '0;
	for (int i = 0; i < chars.size() && i < `KV_PASS_MAX; i++) begin
		d = (d << `KV_DIGEST_ROT) | (d >> (`KV_WORD_W - `KV_DIGEST_ROT)); // rotate left
		d = d ^ {24'd0, chars[i]};
	end
	return d;
endfunction

// right-to-left binary exponentiation, lsb first
function automatic logic [31:0] ref_modexp(input logic [31:0] base, input logic [31:0] e,
	input logic [31:0] m);
	logic [63:0] r;
	logic [63:0] b;
	r = 64'd1 % m; // 1 mod m, zero when m is 1
	b = base % m;
	for (int i = 0; i < 32; i++) begin
		if (e[i]) begin
			r = (r * b) % m;
		end
		b = (b * b) % m;
	end
	return r[31:0];
endfunction

function automatic logic [31:0] lcg_step(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223; // full period mod 2^32
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	if (expected !== actual) begin
		error_count++;
		$display("MISMATCH %s expected %08h actual %08h at %0t", name, expected, actual, $time);
	end
endtask

`endif

/* bench/tb_key_vault.sv */
`timescale 1ns/100ps
`include "keyvault_defines.svh"

module tb_key_vault;
	localparam logic [31:0] SEED = 32'h1a0c5537;
	localparam int NUM_KEYS = 32; // 20 random, 8 slow ack, 2 per exponent edge case
	localparam int WATCHDOG_CYCLES = NUM_KEYS * (2 * `KV_WORD_W + 20) + 400;

	logic                  clk;
	logic                  rst;
	logic                  word_req_i;
	logic [`KV_WORD_W-1:0] word_data_i;
	logic                  word_ack_o;
	logic                  key_valid_i;
	logic [7:0]            key_char_i;
	logic                  key_enter_i;
	logic                  key_clear_i;
	logic                  wrap_req_i;
	logic [`KV_WORD_W-1:0] wrap_data_i;
	logic                  wrap_ack_o;
	logic                  out_req_o;
	logic [`KV_WORD_W-1:0] out_data_o;
	logic                  out_ack_i;
	logic                  led_pass_o;
	logic                  led_fail_o;

	int          error_count = 0;
	int          results_seen = 0;
	int          results_retired = 0; // result handshakes completed
	int          keys_acked = 0;
	logic [31:0] exp_q[$]; // expected results in key order
	logic [7:0]  phrase[$]; // correct passphrase of the current bundle
	logic [31:0] stim_state; // stimulus lcg stream
	logic [31:0] cur_mod;
	logic [31:0] cur_exp;
	int          ack_max_delay; // responder delay bound in cycles
	string       test_name;

	`include "tb_ref_model.svh"

	key_vault_top dut (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period

	function automatic logic [31:0] next_rand();
		stim_state = lcg_step(stim_state);
		return stim_state;
	endfunction

	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		repeat (4) @(negedge clk);
		rst = 1'b0;
	endtask

	// four-phase requester on the bundle port
	task automatic send_word(input logic [31:0] data);
		@(negedge clk);
		word_data_i = data;
		word_req_i = 1'b1;
		do @(negedge clk); while (!word_ack_o);
		word_req_i = 1'b0;
		do @(negedge clk); while (word_ack_o);
	endtask

	// same protocol on the wrapped-key port, expected result queued first
	task automatic send_key(input logic [31:0] key);
		exp_q.push_back(ref_modexp(key, cur_exp, cur_mod));
		@(negedge clk);
		wrap_data_i = key;
		wrap_req_i = 1'b1;
		do @(negedge clk); while (!wrap_ack_o);
		wrap_req_i = 1'b0;
		do @(negedge clk); while (wrap_ack_o);
	endtask

	task automatic strobe_key(input logic [7:0] ch, input logic enter, input logic clear);
		@(negedge clk);
		key_valid_i = !enter && !clear;
		key_char_i = ch;
		key_enter_i = enter;
		key_clear_i = clear;
		@(negedge clk);
		{key_valid_i, key_enter_i, key_clear_i} = 3'b000; // one cycle strobe
	endtask

	task automatic type_phrase(input int count);
		for (int i = 0; i < count; i++) begin
			strobe_key(phrase[i], 1'b0, 1'b0);
		end
	endtask

	task automatic enter_and_wait();
		int n;
		strobe_key(8'h0d, 1'b1, 1'b0);
		n = 0;
		while (!led_pass_o && !led_fail_o && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (!led_pass_o && !led_fail_o) begin
			error_count++;
			$display("no LED came on after enter at %0t", $time);
		end
	endtask

	// new random phrase, bundle words in slot order
	task automatic load_bundle(input logic [31:0] modulus, input logic [31:0] exponent,
		input int len);
		cur_mod = modulus;
		cur_exp = exponent;
		phrase.delete();
		for (int i = 0; i < len; i++) begin
			phrase.push_back(8'(next_rand() >> 24));
		end
		send_word(modulus);
		send_word(exponent);
		send_word(ref_digest(phrase));
	endtask

	task automatic unlock(input int len);
		type_phrase(len);
		enter_and_wait();
		check_value("unlock_leds", 32'd2, {led_pass_o, led_fail_o}); // pass only
	endtask

	task automatic run_keys(input string name, input int count, input int max_delay);
		test_name = name;
		ack_max_delay = max_delay;
		for (int i = 0; i < count; i++) begin
			send_key(next_rand());
		end
		while (exp_q.size() != 0 || out_req_o || out_ack_i) @(negedge clk); // drain
	endtask

	// result check and pending-key monitor in one process
	initial begin : compare_results
		logic        out_prev;
		logic        wrap_prev;
		logic [31:0] expected;
		out_prev = 1'b0;
		wrap_prev = 1'b0;
		forever begin
			@(negedge clk);
			if (wrap_ack_o && !wrap_prev) begin
				if (keys_acked != results_retired) begin
					error_count++;
					$display("wrap_ack_o rose while a result was still pending at %0t", $time);
				end
				keys_acked++;
			end
			if (out_req_o && !out_prev) begin
				if (exp_q.size() == 0) begin
					error_count++;
					$display("result %08h came out with no key outstanding", out_data_o);
				end else begin
					expected = exp_q.pop_front();
					check_value(test_name, expected, out_data_o);
				end
				results_seen++;
			end
			out_prev = out_req_o;
			wrap_prev = wrap_ack_o;
		end
	end

	// result port responder, random ack delay
	initial begin : ack_responder
		logic [31:0] ack_state;
		int          delay;
		out_ack_i = 1'b0;
		ack_state = lcg_step(~SEED); // own stream, apart from stimulus
		forever begin
			@(negedge clk);
			if (out_req_o) begin
				ack_state = lcg_step(ack_state);
				delay = int'(ack_state[23:16]) % (ack_max_delay + 1);
				repeat (delay) @(negedge clk);
				out_ack_i = 1'b1;
				do @(negedge clk); while (out_req_o);
				out_ack_i = 1'b0;
				results_retired++; // handshake back to idle
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, %0d errors so far", WATCHDOG_CYCLES, error_count);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin : main_sequence
		int locked_acks;
		rst = 1'b1;
		{word_req_i, key_valid_i, key_enter_i, key_clear_i, wrap_req_i} = 5'b00000;
		word_data_i = '0;
		wrap_data_i = '0;
		key_char_i = '0;
		stim_state = SEED;
		ack_max_delay = 0;
		test_name = "reset";
		apply_reset();
		check_value("reset_outputs", 32'd0,
			{word_ack_o, wrap_ack_o, out_req_o, led_pass_o, led_fail_o});
		// locked vault must ignore a wrapped key
		wrap_data_i = 32'h0badf00d;
		wrap_req_i = 1'b1;
		locked_acks = 0;
		repeat (50) begin
			@(negedge clk);
			if (wrap_ack_o) begin
				locked_acks++;
			end
		end
		if (locked_acks != 0) begin
			error_count++;
			$display("wrapped key was acknowledged while the vault was locked");
		end
		wrap_req_i = 1'b0;
		load_bundle(next_rand() | 32'd1, next_rand(), 20); // longer than KV_PASS_MAX
		for (int i = 0; i < 5; i++) begin
			strobe_key(8'(next_rand() >> 24), 1'b0, 1'b0); // wrong phrase
		end
		enter_and_wait();
		check_value("wrong_phrase_leds", 32'd1, {led_pass_o, led_fail_o});
		strobe_key(8'h41, 1'b0, 1'b0);
		check_value("fail_led_release", 32'd0, led_fail_o);
		type_phrase(6); // partial, then cleared
		strobe_key(8'h00, 1'b0, 1'b1);
		unlock(20);
		run_keys("random_keys", 20, 3);
		run_keys("slow_ack", 8, 30);
		check_value("pass_led_held", 32'd2, {led_pass_o, led_fail_o});
		apply_reset();
		load_bundle((next_rand() & 32'h0000ffff) | 32'd1, 32'd0, 4); // small modulus
		unlock(4);
		run_keys("exp_zero", 2, 3);
		apply_reset();
		load_bundle((next_rand() & 32'h0000ffff) | 32'd1, 32'd1, 4);
		unlock(4);
		run_keys("exp_one", 2, 3);
		if (results_seen != NUM_KEYS) begin
			error_count++;
			$display("expected %0d results, saw %0d", NUM_KEYS, results_seen);
		end
		$display("run complete: %0d errors, %0d results checked", error_count, results_seen);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+verilog
+incdir+bench
verilog/keyvault_pkg.sv
verilog/key_bundle_loader.sv
verilog/passphrase_gate.sv
verilog/modexp_unit.sv
verilog/key_unwrap_ctrl.sv
verilog/key_vault_top.sv
bench/tb_key_vault.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the key vault testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_key_vault -o tb_key_vault
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_key_vault > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$log"; then
	exit 1
fi
exit 0

/* verilog/key_bundle_loader.sv */
`timescale 1ns/100ps
`include "keyvault_defines.svh"

module key_bundle_loader (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  word_req_i,
	input  logic [`KV_WORD_W-1:0] word_data_i,
	output logic                  word_ack_o,
	output logic [`KV_WORD_W-1:0] modulus_o,
	output logic [`KV_WORD_W-1:0] exponent_o,
	output logic [`KV_WORD_W-1:0] digest_o,
	output logic                  bundle_loaded_o
);
	keyvault_pkg::loader_state_e state_q;
	keyvault_pkg::bundle_slot_e  slot_q; // slot of the next word
	logic                        last_slot; // next word completes the bundle
	logic                        store_word; // word accepted this cycle

	assign last_slot = (slot_q == keyvault_pkg::bundle_slot_e'(`KV_BUNDLE_WORDS - 1));
	assign store_word = (state_q == keyvault_pkg::LD_IDLE) && word_req_i; // only before loaded

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= keyvault_pkg::LD_IDLE;
			slot_q <= keyvault_pkg::SLOT_MODULUS;
			word_ack_o <= 1'b0;
			bundle_loaded_o <= 1'b0;
		end else begin
			case (state_q)
				keyvault_pkg::LD_IDLE: begin
					if (word_req_i) begin
						word_ack_o <= 1'b1; // ack the cycle after req seen
						state_q <= keyvault_pkg::LD_ACK_HIGH;
						if (last_slot) begin
							bundle_loaded_o <= 1'b1; // sticky until reset
						end else begin
							slot_q <= keyvault_pkg::bundle_slot_e'(slot_q + 2'd1);
						end
					end
				end
				keyvault_pkg::LD_ACK_HIGH: begin
					if (!word_req_i) begin
						word_ack_o <= 1'b0; // phase 4
						state_q <= bundle_loaded_o ? keyvault_pkg::LD_LOADED
							: keyvault_pkg::LD_IDLE;
					end
				end
				keyvault_pkg::LD_LOADED: begin
					if (word_req_i) begin
						word_ack_o <= 1'b1; // extra words acked, data dropped
						state_q <= keyvault_pkg::LD_ACK_HIGH;
					end
				end
				default: state_q <= keyvault_pkg::LD_IDLE;
			endcase
		end
	end

	// steer the word into its bundle register
	always_ff @(posedge clk) begin
		if (store_word) begin
			case (slot_q)
				keyvault_pkg::SLOT_MODULUS: modulus_o <= word_data_i;
				keyvault_pkg::SLOT_EXPONENT: exponent_o <= word_data_i;
				keyvault_pkg::SLOT_DIGEST: digest_o <= word_data_i;
				default: ;
			endcase
		end
	end

	// ack only comes up after req was seen high
	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(word_ack_o) |-> $past(word_req_i));

endmodule

/* verilog/key_unwrap_ctrl.sv */
`timescale 1ns/100ps
`include "keyvault_defines.svh"

module key_unwrap_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  vault_open_i,
	input  logic [`KV_WORD_W-1:0] modulus_i,
	input  logic [`KV_WORD_W-1:0] exponent_i,
	input  logic                  wrap_req_i,
	input  logic [`KV_WORD_W-1:0] wrap_data_i,
	output logic                  wrap_ack_o,
	input  logic                  out_ack_i,
	output logic                  out_req_o,
	output logic [`KV_WORD_W-1:0] out_data_o
);
	keyvault_pkg::unwrap_state_e state_q;
	logic [`KV_WORD_W-1:0] key_q; // wrapped key being unwrapped
	logic                  me_start;
	logic                  me_busy;
	logic                  me_done;
	logic [`KV_WORD_W-1:0] me_result;

	// launch on the same edge that drops wrap_ack
	assign me_start = (state_q == keyvault_pkg::UW_DROP_ACK) && !wrap_req_i && !me_busy;

	modexp_unit u_modexp (
		.clk        (clk),
		.rst        (rst),
		.start_i    (me_start),
		.base_i     (key_q),
		.exponent_i (exponent_i),
		.modulus_i  (modulus_i),
		.busy_o     (me_busy),
		.done_o     (me_done),
		.result_o   (me_result)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= keyvault_pkg::UW_WAIT_KEY;
			wrap_ack_o <= 1'b0;
			out_req_o <= 1'b0;
		end else begin
			case (state_q)
				keyvault_pkg::UW_WAIT_KEY: begin
					if (wrap_req_i && vault_open_i) begin
						wrap_ack_o <= 1'b1; // only once unlocked
						state_q <= keyvault_pkg::UW_DROP_ACK;
					end
				end
				keyvault_pkg::UW_DROP_ACK: begin
					if (me_start) begin
						wrap_ack_o <= 1'b0;
						state_q <= keyvault_pkg::UW_COMPUTE;
					end
				end
				keyvault_pkg::UW_COMPUTE: begin
					if (me_done) begin
						out_req_o <= 1'b1; // result registered alongside
						state_q <= keyvault_pkg::UW_OFFER;
					end
				end
				keyvault_pkg::UW_OFFER: begin
					if (out_ack_i) begin
						out_req_o <= 1'b0; // slow ack parks us here
						state_q <= keyvault_pkg::UW_RETIRE;
					end
				end
				keyvault_pkg::UW_RETIRE: begin
					if (!out_ack_i) begin
						state_q <= keyvault_pkg::UW_WAIT_KEY;
					end
				end
				default: state_q <= keyvault_pkg::UW_WAIT_KEY;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == keyvault_pkg::UW_WAIT_KEY && wrap_req_i && vault_open_i) begin
			key_q <= wrap_data_i; // stable while req is up
		end
		if (state_q == keyvault_pkg::UW_COMPUTE && me_done) begin
			out_data_o <= me_result;
		end
	end

	a_offer_held: assert property (@(posedge clk) disable iff (rst)
		out_req_o && !out_ack_i |=> out_req_o && $stable(out_data_o));

endmodule

/* verilog/key_vault_top.sv */
`timescale 1ns/100ps
`include "keyvault_defines.svh"

module key_vault_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  word_req_i,
	input  logic [`KV_WORD_W-1:0] word_data_i,
	output logic                  word_ack_o,
	input  logic                  key_valid_i,
	input  logic [7:0]            key_char_i,
	input  logic                  key_enter_i,
	input  logic                  key_clear_i,
	input  logic                  wrap_req_i,
	input  logic [`KV_WORD_W-1:0] wrap_data_i,
	output logic                  wrap_ack_o,
	output logic                  out_req_o,
	output logic [`KV_WORD_W-1:0] out_data_o,
	input  logic                  out_ack_i,
	output logic                  led_pass_o,
	output logic                  led_fail_o
);
	logic [`KV_WORD_W-1:0] modulus; // loader to unwrap
	logic [`KV_WORD_W-1:0] exponent;
	logic [`KV_WORD_W-1:0] digest; // loader to gate
	logic                  bundle_loaded;
	logic                  vault_open; // gate to unwrap

	key_bundle_loader u_loader (
		.clk (clk), .rst (rst),
		.word_req_i (word_req_i), .word_data_i (word_data_i), .word_ack_o (word_ack_o),
		.modulus_o (modulus), .exponent_o (exponent), .digest_o (digest),
		.bundle_loaded_o (bundle_loaded)
	);

	passphrase_gate u_gate (
		.clk (clk), .rst (rst),
		.bundle_loaded_i (bundle_loaded), .stored_digest_i (digest),
		.key_valid_i (key_valid_i), .key_char_i (key_char_i),
		.key_enter_i (key_enter_i), .key_clear_i (key_clear_i),
		.vault_open_o (vault_open), .led_pass_o (led_pass_o), .led_fail_o (led_fail_o)
	);

	key_unwrap_ctrl u_unwrap (
		.clk (clk), .rst (rst),
		.vault_open_i (vault_open), .modulus_i (modulus), .exponent_i (exponent),
		.wrap_req_i (wrap_req_i), .wrap_data_i (wrap_data_i), .wrap_ack_o (wrap_ack_o),
		.out_ack_i (out_ack_i), .out_req_o (out_req_o), .out_data_o (out_data_o)
	);

endmodule

/* verilog/keyvault_defines.svh */
`ifndef KEYVAULT_DEFINES_SVH
`define KEYVAULT_DEFINES_SVH

// sizing of the key-unwrap vault, shared by every RTL stage

// width of modulus, exponent, digest and wrapped keys
`define KV_WORD_W 32

// bundle words, sent as modulus, exponent, digest
`define KV_BUNDLE_WORDS 3

// keystrokes folded into the digest, later ones are dropped
`define KV_PASS_MAX 16

// left-rotate applied to the digest before each char is xored in
`define KV_DIGEST_ROT 5

`endif

/* verilog/keyvault_pkg.sv */
package keyvault_pkg;

	// order in which bundle words arrive
	typedef enum logic [1:0] {
		SLOT_MODULUS,
		SLOT_EXPONENT,
		SLOT_DIGEST
	} bundle_slot_e;

	typedef enum logic [1:0] {
		LD_IDLE, // waiting for word_req
		LD_ACK_HIGH, // ack up, waiting for req to drop
		LD_LOADED // bundle complete, words still acked
	} loader_state_e;

	typedef enum logic [1:0] {
		GT_COLLECT, // folding keystrokes
		GT_COMPARE, // one cycle digest compare
		GT_OPEN // pass latched until reset
	} gate_state_e;

	typedef enum logic [2:0] {
		UW_WAIT_KEY,
		UW_DROP_ACK,
		UW_COMPUTE,
		UW_OFFER,
		UW_RETIRE
	} unwrap_state_e;

	typedef enum logic [1:0] {
		ME_IDLE,
		ME_SQUARE,
		ME_MULTIPLY,
		ME_FINISH
	} modexp_state_e;

endpackage

/* verilog/modexp_unit.sv */
`timescale 1ns/100ps
`include "keyvault_defines.svh"

module modexp_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_i,
	input  logic [`KV_WORD_W-1:0] base_i,
	input  logic [`KV_WORD_W-1:0] exponent_i,
	input  logic [`KV_WORD_W-1:0] modulus_i,
	output logic                  busy_o,
	output logic                  done_o,
	output logic [`KV_WORD_W-1:0] result_o
);
	localparam int W = `KV_WORD_W;
	localparam int IDX_W = $clog2(`KV_WORD_W);

	keyvault_pkg::modexp_state_e state_q;
	logic [W-1:0]     base_q; // operands latched at start
	logic [W-1:0]     exp_q;
	logic [W-1:0]     mod_q;
	logic [W-1:0]     acc_q; // kept below mod_q after first square
	logic [IDX_W-1:0] bit_q; // exponent bit being scanned
	logic [2*W-1:0]   mod_wide;
	logic [2*W-1:0]   sq_prod; // acc * acc
	logic [2*W-1:0]   mul_prod; // acc * base
	logic [2*W-1:0]   sq_red;
	logic [2*W-1:0]   mul_red;

	assign mod_wide = {{W{1'b0}}, mod_q};
	assign sq_prod = {{W{1'b0}}, acc_q} * {{W{1'b0}}, acc_q};
	assign mul_prod = {{W{1'b0}}, acc_q} * {{W{1'b0}}, base_q};
	assign sq_red = sq_prod % mod_wide; // fits W bits
	assign mul_red = mul_prod % mod_wide;

	assign busy_o = (state_q != keyvault_pkg::ME_IDLE);
	assign done_o = (state_q == keyvault_pkg::ME_FINISH); // single cycle
	assign result_o = acc_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= keyvault_pkg::ME_IDLE;
			bit_q <= '0;
		end else begin
			case (state_q)
				keyvault_pkg::ME_IDLE: begin
					if (start_i) begin
						bit_q <= IDX_W'(W - 1); // scan from msb
						state_q <= keyvault_pkg::ME_SQUARE;
					end
				end
				keyvault_pkg::ME_SQUARE: begin
					if (exp_q[bit_q]) begin
						state_q <= keyvault_pkg::ME_MULTIPLY;
					end else if (bit_q == '0) begin
						state_q <= keyvault_pkg::ME_FINISH;
					end else begin
						bit_q <= bit_q - 1'b1;
					end
				end
				keyvault_pkg::ME_MULTIPLY: begin
					if (bit_q == '0) begin
						state_q <= keyvault_pkg::ME_FINISH;
					end else begin
						bit_q <= bit_q - 1'b1;
						state_q <= keyvault_pkg::ME_SQUARE;
					end
				end
				keyvault_pkg::ME_FINISH: state_q <= keyvault_pkg::ME_IDLE;
				default: state_q <= keyvault_pkg::ME_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == keyvault_pkg::ME_IDLE && start_i) begin
			base_q <= base_i;
			exp_q <= exponent_i;
			mod_q <= modulus_i;
			acc_q <= {{(W-1){1'b0}}, 1'b1}; // reduced by the first square
		end else if (state_q == keyvault_pkg::ME_SQUARE) begin
			acc_q <= sq_red[W-1:0];
		end else if (state_q == keyvault_pkg::ME_MULTIPLY) begin
			acc_q <= mul_red[W-1:0];
		end
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		done_o |=> !done_o);

endmodule

/* verilog/passphrase_gate.sv */
`timescale 1ns/100ps
`include "keyvault_defines.svh"

module passphrase_gate (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  bundle_loaded_i,
	input  logic [`KV_WORD_W-1:0] stored_digest_i,
	input  logic                  key_valid_i,
	input  logic [7:0]            key_char_i,
	input  logic                  key_enter_i,
	input  logic                  key_clear_i,
	output logic                  vault_open_o,
	output logic                  led_pass_o,
	output logic                  led_fail_o
);
	localparam int W = `KV_WORD_W;
	localparam int ROT = `KV_DIGEST_ROT;
	localparam int CNT_W = $clog2(`KV_PASS_MAX + 1);

	keyvault_pkg::gate_state_e state_q;
	logic [W-1:0]     digest_q; // running fold
	logic [W-1:0]     digest_next; // fold with the current char
	logic [CNT_W-1:0] count_q; // keystrokes folded so far
	logic             room; // below the length limit

	// rotate left then xor the zero-extended char
	assign digest_next = {digest_q[W-ROT-1:0], digest_q[W-1:W-ROT]}
		^ {{(W-8){1'b0}}, key_char_i};
	assign room = (count_q < CNT_W'(`KV_PASS_MAX));
	assign vault_open_o = (state_q == keyvault_pkg::GT_OPEN);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= keyvault_pkg::GT_COLLECT;
			digest_q <= '0;
			count_q <= '0;
			led_pass_o <= 1'b0;
			led_fail_o <= 1'b0;
		end else begin
			case (state_q)
				keyvault_pkg::GT_COLLECT: begin
					if (key_clear_i) begin
						digest_q <= '0; // start the phrase over
						count_q <= '0;
						led_fail_o <= 1'b0;
					end else if (key_enter_i && bundle_loaded_i) begin
						state_q <= keyvault_pkg::GT_COMPARE;
					end else if (key_valid_i && bundle_loaded_i) begin
						led_fail_o <= 1'b0; // any keystroke clears a fail
						if (room) begin
							digest_q <= digest_next;
							count_q <= count_q + 1'b1;
						end
					end
				end
				keyvault_pkg::GT_COMPARE: begin
					if (digest_q == stored_digest_i) begin
						led_pass_o <= 1'b1;
						led_fail_o <= 1'b0;
						state_q <= keyvault_pkg::GT_OPEN;
					end else begin
						led_fail_o <= 1'b1;
						digest_q <= '0; // miss resets the fold
						count_q <= '0;
						state_q <= keyvault_pkg::GT_COLLECT;
					end
				end
				keyvault_pkg::GT_OPEN: ; // pass held until reset
				default: state_q <= keyvault_pkg::GT_COLLECT;
			endcase
		end
	end

	a_leds_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(led_pass_o && led_fail_o));

endmodule
